/* src.f */
hdl/mesh_router_pkg.sv
hdl/mesh_pipe_stage.sv
hdl/mesh_route_unit.sv
hdl/mesh_output_arbiter.sv
hdl/mesh_router.sv
verif/mesh_port_monitor.sv
verif/mesh_router_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the mesh router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module mesh_router_tb -f src.f -o mesh_router_sim

./obj_dir/mesh_router_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

/* verif/mesh_router_tb.sv */
module mesh_router_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int NP      = mesh_router_pkg::NUM_PORTS;
    localparam int TIMEOUT = 1000; // Cycles per wait

    logic                        clk = 1'b0;
    logic                        reset_n;
    mesh_router_pkg::node_addr_t node_address;
    mesh_router_pkg::flit_t      in_flit [NP];
    logic [NP-1:0]               in_valid;
    logic [NP-1:0]               in_ready;
    mesh_router_pkg::flit_t      out_flit [NP];
    logic [NP-1:0]               out_valid;
    logic [NP-1:0]               out_ready;
    logic [NP-1:0]               mon_error;
    logic [NP-1:0][15:0]         rcv_count [NP];  // [output][source]
    int                          sent_count [NP][NP]; // [source][output]
    int                          accept_cycle [NP];   // Head acceptance per input
    int                          cycle = 0;
    int                          seed;
    logic                        stress;              // Random back-pressure on

    always #50 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    // Outputs stalled about one cycle in four under stress
    always @(negedge clk) begin
        for (int j = 0; j < NP; j++) begin
            out_ready[j] = stress ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

    mesh_router #(
        .COORD_WIDTH (mesh_router_pkg::COORD_WIDTH)
    ) i_mesh_router (
        .clk          (clk),
        .reset_n      (reset_n),
        .node_address (node_address),
        .in_flit      (in_flit),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_flit     (out_flit),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    for (genvar j = 0; j < NP; j++) begin : g_mon
        mesh_port_monitor #(.PORT(j)) i_port_monitor (
            .clk          (clk),
            .reset_n      (reset_n),
            .node_address (node_address),
            .out_flit     (out_flit[j]),
            .out_valid    (out_valid[j]),
            .out_ready    (out_ready[j]),
            .rcv_count    (rcv_count[j]),
            .error_seen   (mon_error[j])
        );
    end

    always @(mon_error) begin
        if (|mon_error) begin
            $display("TESTS FAILED");
            $fatal(1, "An output monitor saw a bad beat");
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic check_value(string test, int expected, int actual);
        assert (expected == actual) else begin
            $display("[ERROR] %s: expected %0d, actual %0d", test, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic give_up(string what);
        $display("Timed out: %s", what);
        $display("TESTS FAILED");
        $fatal(1, "Wait limit reached");
    endtask

    // Dimension order against row 5, column 5
    function automatic int route_of(logic [3:0] row, logic [3:0] col);
        if (row == node_address.row && col == node_address.col) return 0;
        if (row < node_address.row) return 1;
        if (col > node_address.col) return 3;
        if (row > node_address.row) return 2;
        return 4;
    endfunction

    // Tag in the top byte, address or beat number below
    task automatic send_packet(int src, logic [3:0] row, logic [3:0] col, int len, int id);
        mesh_router_pkg::flit_t beat;
        int                     waited;
        for (int b = 0; b < len; b++) begin
            beat.data = {3'(src), 5'(id), (b == 0) ? {row, col} : 8'(b)};
            beat.sop  = (b == 0);
            beat.eop  = (b == len - 1);
            @(negedge clk);
            in_flit[src]  = beat;
            in_valid[src] = 1'b1;
            #40;
            for (waited = 0; !in_ready[src]; waited++) begin
                if (waited == TIMEOUT) give_up($sformatf("input %0d stuck on a beat", src));
                @(negedge clk);
                #40;
            end
            if (b == 0) accept_cycle[src] = cycle; // Transfer on the coming edge
            sent_count[src][route_of(row, col)]++;
            @(posedge clk);
        end
        @(negedge clk);
        in_valid[src] = 1'b0;
    endtask

    task automatic drive_port(int src, int packets, logic to_east);
        logic [3:0] row;
        logic [3:0] col;
        for (int n = 0; n < packets; n++) begin
            row = to_east ? 4'd5 : 4'(4 + ($random(seed) & 3)); // Rows 4 to 7
            col = to_east ? 4'd9 : 4'(4 + ($random(seed) & 3));
            send_packet(src, row, col, 1 + ($random(seed) & 3), n);
        end
    endtask

    task automatic run_all_inputs(int packets, logic to_east);
        fork
            drive_port(0, packets, to_east);
            drive_port(1, packets, to_east);
            drive_port(2, packets, to_east);
            drive_port(3, packets, to_east);
            drive_port(4, packets, to_east);
        join
    endtask

    // Single beat alone on the node, all outputs ready
    task automatic check_latency(int src, logic [3:0] row, logic [3:0] col, int port);
        int waited;
        send_packet(src, row, col, 1, 0);
        for (waited = 0; waited < TIMEOUT; waited++) begin
            #40;
            if (out_valid[port]) break;
            @(negedge clk);
        end
        if (waited == TIMEOUT) give_up($sformatf("no beat on output %0d", port));
        check_value("zero-contention latency", 2, cycle - accept_cycle[src]);
    endtask

    task automatic check_conservation();
        int missing;
        for (int waited = 0; waited < TIMEOUT; waited++) begin
            @(negedge clk);
            missing = 0;
            for (int p = 0; p < NP; p++) begin
                for (int q = 0; q < NP; q++) begin
                    if (int'(rcv_count[q][p]) != sent_count[p][q]) missing++;
                end
            end
            if (missing == 0) break;
        end
        for (int p = 0; p < NP; p++) begin
            for (int q = 0; q < NP; q++) begin
                check_value($sformatf("beats from input %0d to output %0d", p, q),
                            sent_count[p][q], int'(rcv_count[q][p]));
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------------
    initial begin
        seed         = 38;
        stress       = 1'b0;
        reset_n      = 1'b0;
        node_address = {4'd5, 4'd5}; // Row 5, column 5
        in_valid     = '0;
        out_ready    = '1;
        for (int p = 0; p < NP; p++) begin
            in_flit[p] = '0;
            for (int q = 0; q < NP; q++) sent_count[p][q] = 0;
        end
        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
            reset_n = (c == 15); // Released after the 16th edge
            #40;
            check_value("out_valid in reset", 0, out_valid);
            check_value("in_ready in reset", 31, in_ready);
        end
        @(negedge clk);
        #40;
        check_value("out_valid after reset", 0, out_valid);
        check_value("in_ready after reset", 31, in_ready);
        check_latency(0, 4'd5, 4'd5, 0);
        check_latency(1, 4'd2, 4'd5, 1);
        check_latency(2, 4'd9, 4'd5, 2);
        check_latency(3, 4'd5, 4'd9, 3); // Same row, column larger
        check_latency(4, 4'd5, 4'd1, 4); // Same row, column smaller
        check_latency(0, 4'd3, 4'd9, 1); // North before east
        check_latency(1, 4'd9, 4'd2, 2); // South before west
        run_all_inputs(3, 1'b1);         // Five inputs fight for east
        stress = 1'b1;
        run_all_inputs(20, 1'b0);
        stress = 1'b0;
        check_conservation();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* verif/mesh_port_monitor.sv */
module mesh_port_monitor #(
    parameter int PORT = 0 // Output watched, as a dir_t value
) (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  mesh_router_pkg::node_addr_t                 node_address,
    input  mesh_router_pkg::flit_t                      out_flit,
    input  logic                                        out_valid,
    input  logic                                        out_ready,
    output logic [mesh_router_pkg::NUM_PORTS-1:0][15:0] rcv_count, // Beats per source
    output logic                                        error_seen
);
    timeunit 1ns;
    timeprecision 1ns;

    logic                   in_pkt;    // Between sop and eop
    logic [7:0]             pkt_tag;   // Source and id of the open packet
    logic [7:0]             next_idx;  // Expected body beat number
    logic                   held;      // Beat stalled on the last edge
    mesh_router_pkg::flit_t held_flit;

    // Dimension order, origin at top left
    function automatic int route_of(logic [7:0] addr);
        logic [3:0] row;
        logic [3:0] col;
        row = addr[7:4];
        col = addr[3:0];
        if (row == node_address.row && col == node_address.col) return 0; // here
        if (row < node_address.row) return 1; // north
        if (col > node_address.col) return 3; // east
        if (row > node_address.row) return 2; // south
        return 4;                             // west
    endfunction

    task automatic log_mismatch(string test, int expected, int actual);
        $display("[ERROR] %s on output %0d: expected %0h, actual %0h",
                 test, PORT, expected, actual);
        error_seen = 1'b1;
    endtask

    // ------------------------------------------------------------------
    // One transferred beat
    // ------------------------------------------------------------------
    task automatic check_beat();
        logic [7:0] tag;
        int         src;
        tag = out_flit.data[15:8];
        src = int'(tag[7:5]); // Source port in the top bits
        rcv_count[src] = rcv_count[src] + 16'd1;
        if (out_flit.sop) begin
            assert (!in_pkt) else log_mismatch("packet interleave", pkt_tag, tag);
            assert (route_of(out_flit.data[7:0]) == PORT)
                else log_mismatch("routing rule", PORT, route_of(out_flit.data[7:0]));
            pkt_tag  = tag;
            next_idx = 8'd1;
            in_pkt   = !out_flit.eop; // Single beat packets close at once
        end else begin
            assert (in_pkt) else log_mismatch("body beat outside a packet", 1, 0);
            assert (tag == pkt_tag) else log_mismatch("packet contiguity", pkt_tag, tag);
            assert (out_flit.data[7:0] == next_idx)
                else log_mismatch("beat order", next_idx, out_flit.data[7:0]);
            next_idx = next_idx + 8'd1;
            in_pkt   = !out_flit.eop;
        end
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            rcv_count  = '0;
            in_pkt     = 1'b0;
            held       = 1'b0;
            error_seen = 1'b0;
        end else begin
            if (held) begin // Stalled beat must still be there, unchanged
                assert (out_valid) else log_mismatch("valid under back-pressure", 1, 0);
                assert (out_flit == held_flit)
                    else log_mismatch("beat under back-pressure", held_flit, out_flit);
            end
            if (out_valid && out_ready) begin
                check_beat();
            end
            held      = out_valid && !out_ready;
            held_flit = out_flit;
        end
    end

endmodule

/* hdl/mesh_router.sv */
module mesh_router #(
    parameter int COORD_WIDTH = mesh_router_pkg::COORD_WIDTH
) (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  mesh_router_pkg::node_addr_t            node_address,

    // Packet inputs, indexed by dir_t
    input  mesh_router_pkg::flit_t                 in_flit [mesh_router_pkg::NUM_PORTS],
    input  logic [mesh_router_pkg::NUM_PORTS-1:0] in_valid,
    output logic [mesh_router_pkg::NUM_PORTS-1:0] in_ready,

    // Packet outputs, indexed by dir_t
    output mesh_router_pkg::flit_t                 out_flit [mesh_router_pkg::NUM_PORTS],
    output logic [mesh_router_pkg::NUM_PORTS-1:0] out_valid,
    input  logic [mesh_router_pkg::NUM_PORTS-1:0] out_ready
);

    // ------------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------------
    mesh_router_pkg::routed_flit_t         route_beat [mesh_router_pkg::NUM_PORTS];
    logic [mesh_router_pkg::NUM_PORTS-1:0] route_valid; // Input stage holds a beat
    logic [mesh_router_pkg::NUM_PORTS-1:0] route_ready; // Some arbiter takes it

    // take[j][i] set when output j consumes input i
    logic [mesh_router_pkg::NUM_PORTS-1:0] take [mesh_router_pkg::NUM_PORTS];

    // ------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------
    for (genvar i = 0; i < mesh_router_pkg::NUM_PORTS; i++) begin : g_in
        mesh_route_unit #(
            .COORD_WIDTH (COORD_WIDTH)
        ) i_route_unit (
            .clk          (clk),
            .reset_n      (reset_n),
            .node_address (node_address),
            .in_flit      (in_flit[i]),
            .in_valid     (in_valid[i]),
            .in_ready     (in_ready[i]),
            .out_beat     (route_beat[i]),
            .out_valid    (route_valid[i]),
            .out_ready    (route_ready[i])
        );
    end

    // ------------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------------
    for (genvar j = 0; j < mesh_router_pkg::NUM_PORTS; j++) begin : g_out
        mesh_output_arbiter #(
            .PORT_DIR    (mesh_router_pkg::dir_t'(j)), // Output j serves direction j
            .COORD_WIDTH (COORD_WIDTH)
        ) i_output_arbiter (
            .clk       (clk),
            .reset_n   (reset_n),
            .req_beat  (route_beat),    // Every input seen by every output
            .req_valid (route_valid),
            .take      (take[j]),
            .out_flit  (out_flit[j]),
            .out_valid (out_valid[j]),
            .out_ready (out_ready[j])
        );
    end

    // ------------------------------------------------------------------
    // Ready fan-in
    // ------------------------------------------------------------------
    // A beat names one direction so at most one arbiter claims it
    always_comb begin
        route_ready = '0;
        for (int j = 0; j < mesh_router_pkg::NUM_PORTS; j++) begin
            route_ready = route_ready | take[j]; // OR across outputs
        end
    end

endmodule

/* hdl/mesh_output_arbiter.sv */
module mesh_output_arbiter #(
    parameter mesh_router_pkg::dir_t PORT_DIR    = mesh_router_pkg::here,
    parameter int                    COORD_WIDTH = mesh_router_pkg::COORD_WIDTH
) (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  mesh_router_pkg::routed_flit_t          req_beat [mesh_router_pkg::NUM_PORTS],
    input  logic [mesh_router_pkg::NUM_PORTS-1:0] req_valid,
    output logic [mesh_router_pkg::NUM_PORTS-1:0] take,
    output mesh_router_pkg::flit_t                 out_flit,
    output logic                                   out_valid,
    input  logic                                   out_ready
);

    typedef logic [2:0] port_idx_t; // Input port number

    logic [mesh_router_pkg::NUM_PORTS-1:0] req;   // Inputs heading this way
    mesh_router_pkg::route_state_t         lock_state;
    port_idx_t                             lock_port;  // Owner while locked
    port_idx_t                             rr_ptr;     // First port to consider
    port_idx_t                             rr_port;
    port_idx_t                             grant_port;
    logic                                  rr_found;
    logic                                  grant_valid;
    logic                                  stage_ready;
    logic                                  fire;       // Beat moves into output stage
    mesh_router_pkg::routed_flit_t         stage_beat;
    mesh_router_pkg::routed_flit_t         stage_out;

    // Head address must fit inside one beat
    if (2 * COORD_WIDTH > mesh_router_pkg::DATA_WIDTH) begin : g_addr_width_check
        $error("Address field wider than the beat");
    end

    // ------------------------------------------------------------------
    // Request filter
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < mesh_router_pkg::NUM_PORTS; i++) begin
            req[i] = req_valid[i] && (req_beat[i].dir == PORT_DIR);
        end
    end

    // ------------------------------------------------------------------
    // Round robin search from the pointer
    // ------------------------------------------------------------------
    always_comb begin
        int idx;
        rr_found = 1'b0;
        rr_port  = '0;
        for (int k = 0; k < mesh_router_pkg::NUM_PORTS; k++) begin
            idx = (int'(rr_ptr) + k) % mesh_router_pkg::NUM_PORTS; // Wrap past west
            if (!rr_found && req[idx]) begin
                rr_found = 1'b1;
                rr_port  = port_idx_t'(idx);
            end
        end
    end

    // Locked grant sticks to its owner even when that owner stalls
    always_comb begin
        if (lock_state == mesh_router_pkg::in_packet) begin
            grant_port  = lock_port;
            grant_valid = req[lock_port];
        end else begin
            grant_port  = rr_port;
            grant_valid = rr_found;
        end
    end

    assign stage_beat = req_beat[grant_port]; // Beat mux
    assign fire       = grant_valid && stage_ready;

    always_comb begin
        take = '0;
        if (fire) begin
            take[grant_port] = 1'b1; // Pops the winning input stage
        end
    end

    // ------------------------------------------------------------------
    // Lock and pointer
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            lock_state <= mesh_router_pkg::idle;
            lock_port  <= '0;
            rr_ptr     <= '0;
        end else if (fire) begin
            if (lock_state == mesh_router_pkg::idle) begin
                // New winner, next search starts just after it
                rr_ptr <= (grant_port == port_idx_t'(mesh_router_pkg::NUM_PORTS - 1)) ?
                          '0 : grant_port + 3'd1;
            end
            if (stage_beat.flit.eop) begin
                lock_state <= mesh_router_pkg::idle;
            end else if (stage_beat.flit.sop) begin
                lock_state <= mesh_router_pkg::in_packet;
                lock_port  <= grant_port;
            end
        end
    end

    // ------------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------------
    mesh_pipe_stage i_out_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_beat   (stage_beat),
        .in_valid  (grant_valid),
        .in_ready  (stage_ready),
        .out_beat  (stage_out),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    assign out_flit = stage_out.flit; // Direction tag ends here

endmodule

/* hdl/mesh_route_unit.sv */
module mesh_route_unit #(
    parameter int COORD_WIDTH = mesh_router_pkg::COORD_WIDTH
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  mesh_router_pkg::node_addr_t   node_address,
    input  mesh_router_pkg::flit_t        in_flit,
    input  logic                          in_valid,
    output logic                          in_ready,
    output mesh_router_pkg::routed_flit_t out_beat,
    output logic                          out_valid,
    input  logic                          out_ready
);

    logic [COORD_WIDTH-1:0]        own_row;   // This node
    logic [COORD_WIDTH-1:0]        own_col;
    logic [COORD_WIDTH-1:0]        dest_row;  // From the head beat
    logic [COORD_WIDTH-1:0]        dest_col;
    mesh_router_pkg::dir_t         decision;  // Fresh decision, head beat only
    mesh_router_pkg::dir_t         held_dir;  // Direction for body beats
    mesh_router_pkg::dir_t         beat_dir;
    mesh_router_pkg::route_state_t state;
    mesh_router_pkg::routed_flit_t tagged_beat;
    logic                          accept;

    // ------------------------------------------------------------------
    // Address extraction
    // ------------------------------------------------------------------
    assign own_row  = COORD_WIDTH'(node_address.row);
    assign own_col  = COORD_WIDTH'(node_address.col);
    assign dest_col = in_flit.data[COORD_WIDTH-1:0];             // Column in low bits
    assign dest_row = in_flit.data[2*COORD_WIDTH-1:COORD_WIDTH]; // Row just above

    // ------------------------------------------------------------------
    // Dimension order routing, origin at top left
    // ------------------------------------------------------------------
    always_comb begin
        if (dest_row == own_row && dest_col == own_col) begin
            decision = mesh_router_pkg::here;  // Arrived
        end else if (dest_row < own_row) begin
            decision = mesh_router_pkg::north;
        end else if (dest_col > own_col) begin
            decision = mesh_router_pkg::east;
        end else if (dest_row > own_row) begin
            decision = mesh_router_pkg::south;
        end else begin
            decision = mesh_router_pkg::west;  // Same row, smaller column
        end
    end

    // Body beats follow the head
    assign beat_dir = (state == mesh_router_pkg::in_packet) ? held_dir : decision;

    assign tagged_beat.flit = in_flit;
    assign tagged_beat.dir  = beat_dir;

    assign accept = in_valid && in_ready;

    // ------------------------------------------------------------------
    // Packet tracking
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= mesh_router_pkg::idle;
            held_dir <= mesh_router_pkg::here;
        end else if (accept) begin
            if (in_flit.eop) begin
                state <= mesh_router_pkg::idle; // Single beat packets never leave idle
            end else if (in_flit.sop) begin
                state    <= mesh_router_pkg::in_packet;
                held_dir <= decision;           // Latch at the head
            end
        end
    end

    // ------------------------------------------------------------------
    // Input stage
    // ------------------------------------------------------------------
    mesh_pipe_stage i_in_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_beat   (tagged_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* hdl/mesh_pipe_stage.sv */
module mesh_pipe_stage (
    input  logic                          clk,
    input  logic                          reset_n,
    input  mesh_router_pkg::routed_flit_t in_beat,
    input  logic                          in_valid,
    output logic                          in_ready,
    output mesh_router_pkg::routed_flit_t out_beat,
    output logic                          out_valid,
    input  logic                          out_ready
);

    logic accept; // Beat enters the stage this cycle

    // ------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------
    // Ready when empty or when the held beat leaves this cycle
    assign in_ready = out_ready || !out_valid;
    assign accept   = in_valid && in_ready;

    // Valid only set on an accepted beat
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0; // Drained, nothing new
        end
    end

    // ------------------------------------------------------------------
    // Payload register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            out_beat <= in_beat; // Held stable until taken
        end
    end

endmodule

/* hdl/mesh_router_pkg.sv */
package mesh_router_pkg;

    // ------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------
    parameter int NUM_PORTS   = 5;  // Fixed by the direction enum
    parameter int COORD_WIDTH = 4;  // Default width of one coordinate
    parameter int DATA_WIDTH  = 16; // One symbol per beat

    // ------------------------------------------------------------------
    // Addressing
    // ------------------------------------------------------------------
    typedef logic [COORD_WIDTH-1:0] coord_t; // Column or row
    typedef logic [DATA_WIDTH-1:0]  data_t;  // Beat payload

    // Row in the upper half, column in the lower half
    typedef struct packed {
        coord_t row;
        coord_t col;
    } node_addr_t;

    // Encodings double as port indices
    typedef enum logic [2:0] {
        here  = 3'd0,
        north = 3'd1,
        south = 3'd2,
        east  = 3'd3,
        west  = 3'd4
    } dir_t;

    // ------------------------------------------------------------------
    // Beats
    // ------------------------------------------------------------------
    typedef struct packed {
        data_t data; // Head beat holds {row, col} in the low bits
        logic  sop;  // Start of packet
        logic  eop;  // End of packet
    } flit_t;

    // Beat tagged with its output direction
    typedef struct packed {
        flit_t flit;
        dir_t  dir;
    } routed_flit_t;

    // Packet tracking in route units and arbiters
    typedef enum logic {
        idle,
        in_packet
    } route_state_t;

endpackage
